// File: graph_arbiter_consts.svh
`ifndef GRAPH_ARBITER_CONSTS_SVH
`define GRAPH_ARBITER_CONSTS_SVH

// Compute unit count and the width of its index
`define GA_NUM_CU 4
`define GA_CU_ID_BITS 2

// Field widths
`define GA_ADDR_BITS 32
`define GA_TAG_BITS 8
`define GA_DATA_BITS 32
`define GA_VERTEX_BITS 32
`define GA_DEGREE_BITS 32
`define GA_EDGE_BITS 32

// Buffer depths
`define GA_CMD_FIFO_DEPTH 16
`define GA_JOB_FIFO_DEPTH 8

// Almost-full when this many free entries or fewer remain
`define GA_ALFULL_MARGIN 2

`endif

// File: graph_arbiter_pkg.sv
`default_nettype none

`include "graph_arbiter_consts.svh"

package graph_arbiter_pkg;

	typedef logic [`GA_CU_ID_BITS-1:0] cu_id_t;

	// Read command toward memory
	typedef struct packed {
		cu_id_t                   cu_id;
		logic [`GA_TAG_BITS-1:0]  tag;
		logic [`GA_ADDR_BITS-1:0] addr;
	} command_t;

	typedef struct packed {
		logic     valid;
		command_t payload;
	} command_line_t;

	typedef struct packed {
		logic                     valid;
		cu_id_t                   cu_id;
		logic [`GA_TAG_BITS-1:0]  tag;
		logic [`GA_DATA_BITS-1:0] data;
	} response_line_t;

	typedef struct packed {
		logic [`GA_VERTEX_BITS-1:0] vertex_id;
		logic [`GA_DEGREE_BITS-1:0] degree;
	} vertex_job_t;

	typedef struct packed {
		logic        valid;
		vertex_job_t payload;
	} vertex_line_t;

	typedef struct packed {
		logic full;
		logic alfull;
		logic empty;
	} fifo_status_t;

	// Rotating priority picks the first requester after the last winner
	// Last winner itself comes last in line
	function automatic cu_id_t rr_next(input logic [`GA_NUM_CU-1:0] requests,
		input cu_id_t last);
		cu_id_t pick;
		cu_id_t idx;
		pick = last;
		for (int k = `GA_NUM_CU; k >= 1; k--) begin
			idx = cu_id_t'((int'(last) + k) % `GA_NUM_CU);
			if (requests[idx])
				pick = idx;
		end
		return pick;
	endfunction

endpackage

`default_nettype wire

// File: sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int  DEPTH         = 16,
	parameter int  ALFULL_MARGIN = 2,
	parameter type entry_t       = logic [31:0]
) (
	input  wire logic                          clock,
	input  wire logic                          rstn,
	input  wire logic                          push,
	input  wire entry_t                        data_in,
	input  wire logic                          pop,
	output entry_t                             data_out,
	output graph_arbiter_pkg::fifo_status_t    status
);

	localparam int PTR_BITS   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_BITS = $clog2(DEPTH + 1);

	entry_t                mem [DEPTH];
	logic [PTR_BITS-1:0]   rd_ptr;
	logic [PTR_BITS-1:0]   wr_ptr;
	logic [COUNT_BITS-1:0] count;
	logic                  do_push;
	logic                  do_pop;

	// Writes to a full FIFO and reads from an empty one are dropped
	assign do_push = push && !status.full;
	assign do_pop  = pop && !status.empty;

	assign status.full   = (count == COUNT_BITS'(DEPTH));
	assign status.empty  = (count == '0);
	assign status.alfull = ((COUNT_BITS'(DEPTH) - count) <= COUNT_BITS'(ALFULL_MARGIN));

	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: cu_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "graph_arbiter_consts.svh"

module cu_lane #(
	parameter int LANE_ID = 0
) (
	input  wire logic                              clock,
	input  wire logic                              rstn,
	input  wire graph_arbiter_pkg::command_line_t  command,
	output logic                                   command_ready,
	output graph_arbiter_pkg::command_line_t       slot,
	input  wire logic                              slot_take,
	input  wire logic                              job_request_in,
	output logic                                   job_request,
	input  wire graph_arbiter_pkg::response_line_t response_in,
	output graph_arbiter_pkg::response_line_t      response,
	input  wire graph_arbiter_pkg::vertex_line_t   job_in,
	output graph_arbiter_pkg::vertex_line_t        job,
	input  wire logic [`GA_VERTEX_BITS-1:0]        vertex_done_in,
	output logic [`GA_VERTEX_BITS-1:0]             vertex_done,
	input  wire logic [`GA_EDGE_BITS-1:0]          edge_done_in,
	output logic [`GA_EDGE_BITS-1:0]               edge_done
);
	import graph_arbiter_pkg::*;

	logic     slot_valid;
	command_t slot_command;

	////////////////////
	// Command slot
	////////////////////

	assign command_ready = !slot_valid;
	assign slot          = '{valid: slot_valid, payload: slot_command};

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			slot_valid <= 1'b0;
		end else if (slot_take) begin
			slot_valid <= 1'b0;
		end else if (command.valid && !slot_valid) begin
			slot_valid <= 1'b1;
		end
	end

	// Own id stamped so the response finds the way back
	always_ff @(posedge clock) begin
		if (command.valid && !slot_valid) begin
			slot_command       <= command.payload;
			slot_command.cu_id <= cu_id_t'(LANE_ID);
		end
	end

	////////////////////
	// Registers toward the CU
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_request <= 1'b0;
			response    <= '0;
			job         <= '0;
			vertex_done <= '0;
			edge_done   <= '0;
		end else begin
			job_request <= job_request_in;
			response    <= response_in;
			job         <= job_in;
			vertex_done <= vertex_done_in;
			edge_done   <= edge_done_in;
		end
	end

endmodule

`default_nettype wire

// File: command_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "graph_arbiter_consts.svh"

module command_arbiter (
	input  wire logic                             clock,
	input  wire logic                             rstn,
	input  wire logic                             enabled,
	input  wire graph_arbiter_pkg::command_line_t slots [`GA_NUM_CU],
	output logic [`GA_NUM_CU-1:0]                 slot_take,
	input  wire logic                             mem_alfull,
	input  wire logic                             mem_command_grant,
	output logic                                  mem_command_request,
	output graph_arbiter_pkg::command_line_t      mem_command
);
	import graph_arbiter_pkg::*;

	logic [`GA_NUM_CU-1:0] slot_valid;
	cu_id_t                last_winner;
	cu_id_t                winner;
	logic                  pick;
	logic                  pop;
	command_t              head;
	fifo_status_t          status;

	////////////////////
	// Round-robin pick
	////////////////////

	always_comb begin
		for (int i = 0; i < `GA_NUM_CU; i++) begin
			slot_valid[i] = slots[i].valid;
		end
	end

	assign winner = rr_next(slot_valid, last_winner);

	// Stop taking slots once the burst FIFO is nearly full
	assign pick = enabled && !status.alfull && (|slot_valid);

	always_comb begin
		slot_take = '0;
		if (pick)
			slot_take[winner] = 1'b1;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_winner <= cu_id_t'(`GA_NUM_CU - 1);
		end else if (pick) begin
			last_winner <= winner;
		end
	end

	////////////////////
	// Burst command FIFO
	////////////////////

	sync_fifo #(
		.DEPTH        (`GA_CMD_FIFO_DEPTH),
		.ALFULL_MARGIN(`GA_ALFULL_MARGIN ),
		.entry_t      (command_t         )
	) command_fifo (
		.clock   (clock                ),
		.rstn    (rstn                 ),
		.push    (pick                 ),
		.data_in (slots[winner].payload),
		.pop     (pop                  ),
		.data_out(head                 ),
		.status  (status               )
	);

	// Memory bus request and grant
	assign pop = mem_command_grant && !mem_alfull && !status.empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			mem_command_request <= 1'b0;
			mem_command         <= '0;
		end else begin
			mem_command_request <= !status.empty && !mem_alfull;
			mem_command.valid   <= pop;
			if (pop)
				mem_command.payload <= head;
		end
	end

endmodule

`default_nettype wire

// File: cu_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "graph_arbiter_consts.svh"

module cu_dispatch (
	input  wire logic                              clock,
	input  wire logic                              rstn,
	input  wire logic                              enabled,
	input  wire graph_arbiter_pkg::response_line_t response,
	output graph_arbiter_pkg::response_line_t      lane_response [`GA_NUM_CU],
	input  wire graph_arbiter_pkg::vertex_line_t   vertex_job,
	output logic                                   vertex_job_request,
	input  wire logic [`GA_NUM_CU-1:0]             lane_job_request,
	output graph_arbiter_pkg::vertex_line_t        lane_job [`GA_NUM_CU]
);
	import graph_arbiter_pkg::*;

	vertex_job_t  head;
	fifo_status_t status;
	cu_id_t       last_lane;
	cu_id_t       next_lane;
	logic         hand_out;

	////////////////////
	// Response routing
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			for (int i = 0; i < `GA_NUM_CU; i++) begin
				lane_response[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `GA_NUM_CU; i++) begin
				lane_response[i]       <= response;
				lane_response[i].valid <= response.valid && (response.cu_id == cu_id_t'(i));
			end
		end
	end

	////////////////////
	// Vertex job buffer
	////////////////////

	sync_fifo #(
		.DEPTH        (`GA_JOB_FIFO_DEPTH),
		.ALFULL_MARGIN(`GA_ALFULL_MARGIN ),
		.entry_t      (vertex_job_t      )
	) job_fifo (
		.clock   (clock             ),
		.rstn    (rstn              ),
		.push    (vertex_job.valid  ),
		.data_in (vertex_job.payload),
		.pop     (hand_out          ),
		.data_out(head              ),
		.status  (status            )
	);

	// Head job goes to the next requesting lane
	assign next_lane = rr_next(lane_job_request, last_lane);
	assign hand_out  = enabled && !status.empty && (|lane_job_request);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_job_request <= 1'b0;
			last_lane          <= cu_id_t'(`GA_NUM_CU - 1);
			for (int i = 0; i < `GA_NUM_CU; i++) begin
				lane_job[i] <= '0;
			end
		end else begin
			vertex_job_request <= !status.alfull;
			if (hand_out)
				last_lane <= next_lane;
			for (int i = 0; i < `GA_NUM_CU; i++) begin
				lane_job[i].valid   <= hand_out && (next_lane == cu_id_t'(i));
				lane_job[i].payload <= head;
			end
		end
	end

endmodule

`default_nettype wire

// File: done_reduce.sv
`timescale 1ns/1ps
`default_nettype none

`include "graph_arbiter_consts.svh"

module done_reduce (
	input  wire logic                       clock,
	input  wire logic                       rstn,
	input  wire logic [`GA_VERTEX_BITS-1:0] vertex_done [`GA_NUM_CU],
	input  wire logic [`GA_EDGE_BITS-1:0]   edge_done [`GA_NUM_CU],
	output logic [`GA_VERTEX_BITS-1:0]      vertex_done_total,
	output logic [`GA_EDGE_BITS-1:0]        edge_done_total
);

	logic [`GA_VERTEX_BITS-1:0] vertex_sum;
	logic [`GA_EDGE_BITS-1:0]   edge_sum;

	// Sums wrap at the counter width
	always_comb begin
		vertex_sum = '0;
		edge_sum   = '0;
		for (int i = 0; i < `GA_NUM_CU; i++) begin
			vertex_sum = vertex_sum + vertex_done[i];
			edge_sum   = edge_sum + edge_done[i];
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done_total <= '0;
			edge_done_total   <= '0;
		end else begin
			vertex_done_total <= vertex_sum;
			edge_done_total   <= edge_sum;
		end
	end

endmodule

`default_nettype wire

// File: graph_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "graph_arbiter_consts.svh"

module graph_arbiter (
	input  wire logic                              clock,
	input  wire logic                              rstn,
	input  wire logic                              enabled,
	input  wire graph_arbiter_pkg::command_line_t  cu_command [`GA_NUM_CU],
	output logic [`GA_NUM_CU-1:0]                  cu_command_ready,
	input  wire logic [`GA_NUM_CU-1:0]             cu_job_request,
	output graph_arbiter_pkg::response_line_t      cu_response [`GA_NUM_CU],
	output graph_arbiter_pkg::vertex_line_t        cu_job [`GA_NUM_CU],
	input  wire logic [`GA_VERTEX_BITS-1:0]        cu_vertex_done [`GA_NUM_CU],
	input  wire logic [`GA_EDGE_BITS-1:0]          cu_edge_done [`GA_NUM_CU],
	output logic                                   mem_command_request,
	input  wire logic                              mem_command_grant,
	input  wire logic                              mem_alfull,
	output graph_arbiter_pkg::command_line_t       mem_command,
	input  wire graph_arbiter_pkg::response_line_t response,
	input  wire graph_arbiter_pkg::vertex_line_t   vertex_job,
	output logic                                   vertex_job_request,
	output logic [`GA_VERTEX_BITS-1:0]             vertex_done_total,
	output logic [`GA_EDGE_BITS-1:0]               edge_done_total
);
	import graph_arbiter_pkg::*;

	command_line_t              slots [`GA_NUM_CU];
	logic [`GA_NUM_CU-1:0]      slot_take;
	response_line_t             lane_response [`GA_NUM_CU];
	vertex_line_t               lane_job [`GA_NUM_CU];
	logic [`GA_NUM_CU-1:0]      lane_job_request;
	logic [`GA_VERTEX_BITS-1:0] lane_vertex_done [`GA_NUM_CU];
	logic [`GA_EDGE_BITS-1:0]   lane_edge_done [`GA_NUM_CU];

	cu_dispatch dispatch (
		.clock             (clock             ),
		.rstn              (rstn              ),
		.enabled           (enabled           ),
		.response          (response          ),
		.lane_response     (lane_response     ),
		.vertex_job        (vertex_job        ),
		.vertex_job_request(vertex_job_request),
		.lane_job_request  (lane_job_request  ),
		.lane_job          (lane_job          )
	);

	////////////////////
	// One lane per CU
	////////////////////

	genvar i;
	generate
		for (i = 0; i < `GA_NUM_CU; i++) begin : gen_lane
			cu_lane #(
				.LANE_ID(i)
			) lane (
				.clock         (clock              ),
				.rstn          (rstn               ),
				.command       (cu_command[i]      ),
				.command_ready (cu_command_ready[i]),
				.slot          (slots[i]           ),
				.slot_take     (slot_take[i]       ),
				.job_request_in(cu_job_request[i]  ),
				.job_request   (lane_job_request[i]),
				.response_in   (lane_response[i]   ),
				.response      (cu_response[i]     ),
				.job_in        (lane_job[i]        ),
				.job           (cu_job[i]          ),
				.vertex_done_in(cu_vertex_done[i]  ),
				.vertex_done   (lane_vertex_done[i]),
				.edge_done_in  (cu_edge_done[i]    ),
				.edge_done     (lane_edge_done[i]  )
			);
		end
	endgenerate

	command_arbiter arbiter (
		.clock              (clock              ),
		.rstn               (rstn               ),
		.enabled            (enabled            ),
		.slots              (slots              ),
		.slot_take          (slot_take          ),
		.mem_alfull         (mem_alfull         ),
		.mem_command_grant  (mem_command_grant  ),
		.mem_command_request(mem_command_request),
		.mem_command        (mem_command        )
	);

	done_reduce reduce (
		.clock            (clock            ),
		.rstn             (rstn             ),
		.vertex_done      (lane_vertex_done ),
		.edge_done        (lane_edge_done   ),
		.vertex_done_total(vertex_done_total),
		.edge_done_total  (edge_done_total  )
	);

endmodule

`default_nettype wire

// File: graph_arbiter_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "graph_arbiter_consts.svh"

module graph_arbiter_properties (
	input  wire logic                            clock,
	input  wire logic                            rstn,
	input  wire logic                            mem_alfull,
	input  wire logic                            mem_command_grant,
	input  wire logic                            mem_command_request,
	input  wire graph_arbiter_pkg::command_line_t mem_command,
	input  wire graph_arbiter_pkg::vertex_line_t  cu_job [`GA_NUM_CU]
);

	logic [`GA_NUM_CU-1:0] job_valid;

	always_comb begin
		for (int i = 0; i < `GA_NUM_CU; i++) begin
			job_valid[i] = cu_job[i].valid;
		end
	end

	// A command leaves only on the cycle after a grant
	command_after_grant: assert property (@(posedge clock) disable iff (!rstn)
		mem_command.valid |-> $past(mem_command_grant))
		else $error("mem_command valid without a grant on the previous cycle");

	request_held_off: assert property (@(posedge clock) disable iff (!rstn)
		$past(mem_alfull) |-> !mem_command_request)
		else $error("mem_command_request high while memory was almost full");

	// Never two CUs served at once
	single_job: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(job_valid))
		else $error("more than one cu_job valid in one cycle");

endmodule

`default_nettype wire

// File: graph_arbiter_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "graph_arbiter_consts.svh"

module graph_arbiter_tb;
	import graph_arbiter_pkg::*;

	localparam int TIMEOUT = 1000;

	logic                       clock;
	logic                       rstn;
	logic                       enabled;
	command_line_t              cu_command [`GA_NUM_CU];
	logic [`GA_NUM_CU-1:0]      cu_command_ready;
	logic [`GA_NUM_CU-1:0]      cu_job_request;
	response_line_t             cu_response [`GA_NUM_CU];
	vertex_line_t               cu_job [`GA_NUM_CU];
	logic [`GA_VERTEX_BITS-1:0] cu_vertex_done [`GA_NUM_CU];
	logic [`GA_EDGE_BITS-1:0]   cu_edge_done [`GA_NUM_CU];
	logic                       mem_command_request;
	logic                       mem_command_grant;
	logic                       mem_alfull;
	command_line_t              mem_command;
	response_line_t             response;
	vertex_line_t               vertex_job;
	logic                       vertex_job_request;
	logic [`GA_VERTEX_BITS-1:0] vertex_done_total;
	logic [`GA_EDGE_BITS-1:0]   edge_done_total;

	command_t    expected_commands [$];
	int          error_count;
	int          fd;
	int          code;
	int          wait_count;
	int          found;
	int          match;
	logic [7:0]  kind;
	logic [1023:0] skip_line;
	logic [31:0] f0;
	logic [31:0] f1;
	logic [31:0] f2;
	logic [31:0] vd [4];
	logic [31:0] ed [4];
	logic [31:0] vertex_sum;
	logic [31:0] edge_sum;
	logic [31:0] stim_state;
	logic [31:0] gap_state;
	logic [31:0] rand_value;
	logic [2:0]  gap;
	logic [`GA_NUM_CU-1:0] driven;

	graph_arbiter uut (.*);

	bind graph_arbiter graph_arbiter_properties props (
		.clock              (clock              ),
		.rstn               (rstn               ),
		.mem_alfull         (mem_alfull         ),
		.mem_command_grant  (mem_command_grant  ),
		.mem_command_request(mem_command_request),
		.mem_command        (mem_command        ),
		.cu_job             (cu_job             )
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	////////////////////
	// Helpers
	////////////////////

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int k = 0; k < n; k++) begin
			stim_state = lfsr_next(stim_state);
			value = {value[30:0], stim_state[0]};
		end
	endtask

	task automatic stop_run(input string what);
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			error_count++;
			$display("FAIL %s: got %0h expected %0h", name, actual, expected);
			$display(">>> FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_reset_outputs();
		check_value("mem_command_request", mem_command_request, 0);
		check_value("mem_command.valid", mem_command.valid, 0);
		check_value("vertex_job_request", vertex_job_request, 0);
		check_value("vertex_done_total", vertex_done_total, 0);
		check_value("edge_done_total", edge_done_total, 0);
		check_value("cu_command_ready", cu_command_ready, {`GA_NUM_CU{1'b1}});
		for (int i = 0; i < `GA_NUM_CU; i++) begin
			check_value($sformatf("cu_response[%0d].valid", i), cu_response[i].valid, 0);
			check_value($sformatf("cu_job[%0d].valid", i), cu_job[i].valid, 0);
		end
	endtask

	task automatic issue_command(input int cu, input logic [7:0] tag, input logic [31:0] addr);
		int n;
		n = 0;
		@(posedge clock);
		while (!cu_command_ready[cu]) begin
			n++;
			if (n > TIMEOUT)
				stop_run($sformatf("Timeout: CU %0d command slot never became ready", cu));
			@(posedge clock);
		end
		cu_command[cu] <= '{valid: 1'b1, payload: '{cu_id: '0, tag: tag, addr: addr}};
		expected_commands.push_back(command_t'{cu_id: cu_id_t'(cu), tag: tag, addr: addr});
		@(posedge clock);
		cu_command[cu] <= '0;
	endtask

	////////////////////
	// Memory model and command monitor
	////////////////////

	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			mem_command_grant <= 1'b0;
			gap_state         = 32'h8eca3fd9;
			gap               = 3'd1;
		end else if (mem_command_grant) begin
			mem_command_grant <= 1'b0;
		end else if (mem_command_request && !mem_alfull) begin
			if (gap == 0) begin
				mem_command_grant <= 1'b1;
				gap_state = lfsr_next(gap_state);
				gap[0]    = gap_state[0];
				gap_state = lfsr_next(gap_state);
				gap[1]    = gap_state[0];
				gap[2]    = 1'b0;
			end else begin
				gap = gap - 1'b1;
			end
		end
	end

	always @(posedge clock) begin
		if (rstn && mem_command.valid) begin
			match = -1;
			for (int k = 0; k < expected_commands.size(); k++) begin
				if (match < 0 && expected_commands[k].cu_id == mem_command.payload.cu_id)
					match = k;
			end
			if (match < 0)
				stop_run($sformatf("Unexpected command on mem_command from CU %0d",
					mem_command.payload.cu_id));
			check_value("mem_command.tag", mem_command.payload.tag,
				expected_commands[match].tag);
			check_value("mem_command.addr", mem_command.payload.addr,
				expected_commands[match].addr);
			expected_commands.delete(match);
		end
	end

	////////////////////
	// Stimulus from the cases file
	////////////////////

	initial begin
		error_count = 0;
		stim_state  = 32'h8eca3fd9;
		rstn        = 1'b0;
		enabled     = 1'b0;
		mem_alfull  = 1'b0;
		response    = '0;
		vertex_job  = '0;
		cu_job_request = '0;
		for (int i = 0; i < `GA_NUM_CU; i++) begin
			cu_command[i]     = '0;
			cu_vertex_done[i] = '0;
			cu_edge_done[i]   = '0;
		end
		vertex_sum = '0;
		edge_sum   = '0;
		repeat (5) begin
			@(posedge clock);
			check_reset_outputs();
		end
		rstn    <= 1'b1;
		enabled <= 1'b1;
		@(posedge clock);
		check_reset_outputs();

		fd = $fopen("graph_arbiter_cases.txt", "r");
		if (fd == 0)
			stop_run("Could not open graph_arbiter_cases.txt");
		while (!$feof(fd)) begin
			code = $fscanf(fd, " %c", kind);
			if (code != 1)
				break;
			case (kind)
				"#": code = $fgets(skip_line, fd);
				"C": begin
					code = $fscanf(fd, "%h %h %h", f0, f1, f2);
					issue_command(int'(f0), f1[7:0], f2);
				end
				"R": begin
					code = $fscanf(fd, "%h %h %h", f0, f1, f2);
					@(posedge clock);
					response <= '{valid: 1'b1, cu_id: cu_id_t'(f0), tag: f1[7:0], data: f2};
					@(posedge clock);
					response <= '0;
					@(posedge clock);
					for (int i = 0; i < `GA_NUM_CU; i++)
						check_value($sformatf("cu_response[%0d].valid", i), cu_response[i].valid, 0);
					@(posedge clock);
					for (int i = 0; i < `GA_NUM_CU; i++)
						check_value($sformatf("cu_response[%0d].valid", i),
							cu_response[i].valid, (i == int'(f0)));
					check_value("cu_response.tag", cu_response[f0].tag, f1[7:0]);
					check_value("cu_response.data", cu_response[f0].data, f2);
				end
				"J": begin
					code = $fscanf(fd, "%h %h %h", f0, f1, f2);
					@(posedge clock);
					// Job buffer is drained here, so it can take more
					check_value("vertex_job_request", vertex_job_request, 1);
					cu_job_request <= f2[`GA_NUM_CU-1:0];
					vertex_job     <= '{valid: 1'b1, payload: '{vertex_id: f0, degree: f1}};
					@(posedge clock);
					vertex_job <= '0;
					wait_count = 0;
					found      = -1;
					while (found < 0) begin
						@(posedge clock);
						for (int i = 0; i < `GA_NUM_CU; i++)
							if (cu_job[i].valid)
								found = i;
						wait_count++;
						if (found < 0 && wait_count > TIMEOUT)
							stop_run("Timeout: vertex job was never handed to a CU");
					end
					check_value("cu_job requester", f2[found], 1);
					check_value("cu_job.vertex_id", cu_job[found].payload.vertex_id, f0);
					check_value("cu_job.degree", cu_job[found].payload.degree, f1);
					cu_job_request <= '0;
				end
				"D": begin
					code = $fscanf(fd, "%h %h %h %h %h %h %h %h",
						vd[0], vd[1], vd[2], vd[3], ed[0], ed[1], ed[2], ed[3]);
					@(posedge clock);
					for (int i = 0; i < `GA_NUM_CU; i++) begin
						cu_vertex_done[i] <= vd[i];
						cu_edge_done[i]   <= ed[i];
					end
					repeat (2) @(posedge clock);
					// Old totals still hold one cycle short of the latency
					check_value("vertex_done_total", vertex_done_total, vertex_sum);
					check_value("edge_done_total", edge_done_total, edge_sum);
					vertex_sum = vd[0] + vd[1] + vd[2] + vd[3];
					edge_sum   = ed[0] + ed[1] + ed[2] + ed[3];
					@(posedge clock);
					check_value("vertex_done_total", vertex_done_total, vertex_sum);
					check_value("edge_done_total", edge_done_total, edge_sum);
				end
				"P": begin
					code   = $fscanf(fd, "%h", f0);
					driven = '0;
					@(posedge clock);
					mem_alfull <= 1'b1;
					// Random commands on every free slot fill the burst FIFO
					for (int c = 0; c < int'(f0); c++) begin
						@(posedge clock);
						if (c >= 1) begin
							check_value("mem_command_request", mem_command_request, 0);
							check_value("mem_command.valid", mem_command.valid, 0);
						end
						for (int i = 0; i < `GA_NUM_CU; i++) begin
							if (cu_command_ready[i] && !driven[i]) begin
								draw_bits(32, rand_value);
								f1 = rand_value;
								draw_bits(8, rand_value);
								cu_command[i] <= '{valid: 1'b1,
									payload: '{cu_id: '0, tag: rand_value[7:0], addr: f1}};
								expected_commands.push_back(command_t'{cu_id: cu_id_t'(i),
									tag: rand_value[7:0], addr: f1});
								driven[i] = 1'b1;
							end else begin
								cu_command[i] <= '0;
								driven[i] = 1'b0;
							end
						end
					end
					@(posedge clock);
					for (int i = 0; i < `GA_NUM_CU; i++)
						cu_command[i] <= '0;
					mem_alfull <= 1'b0;
				end
				default: stop_run($sformatf("Unknown record kind %c in cases file", kind));
			endcase
		end
		$fclose(fd);

		wait_count = 0;
		while (expected_commands.size() > 0) begin
			@(posedge clock);
			wait_count++;
			if (wait_count > TIMEOUT)
				stop_run("Timeout: pending commands never reached mem_command");
		end
		repeat (4) @(posedge clock);
		if (error_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: graph_arbiter_cases.txt
# C cu tag addr | R cu tag data | J vertex degree request_mask | P alfull_cycles
# D vertex0 vertex1 vertex2 vertex3 edge0 edge1 edge2 edge3 (all fields hex)
C 0 11 00001000
C 1 12 00002000
C 2 13 00003000
C 3 14 00004000
C 0 15 00001040
C 2 16 00003040
P 28
C 1 17 00002040
R 2 a5 deadbeef
R 0 3c 01234567
R 3 ff cafef00d
J 00000010 00000003 6
J 00000011 00000007 1
J 00000012 0000000b f
D 00000001 00000002 00000003 00000004 00000010 00000020 00000030 00000040
D ffffffff 00000002 80000000 80000000 ffffffff ffffffff 00000001 00000001
C 3 18 00004040
R 1 77 00000000

// File: graph_arbiter.f
+incdir+.
graph_arbiter_pkg.sv
sync_fifo.sv
cu_lane.sv
command_arbiter.sv
cu_dispatch.sv
done_reduce.sv
graph_arbiter.sv
graph_arbiter_properties.sv
graph_arbiter_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the graph arbiter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f graph_arbiter.f \
	--top-module graph_arbiter_tb \
	-o sim_graph_arbiter

# The simulator exits nonzero on a fatal check; the log decides the result
./obj_dir/sim_graph_arbiter > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
	exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
	exit 1
fi
exit 0
